// ==== data_mem.f ====
+incdir+hw
+incdir+verif
hw/data_mem_pkg.sv
hw/mem_req_steer.sv
hw/mem_byte_bank.sv
hw/mem_load_format.sv
hw/data_mem.sv
verif/data_mem_tb.sv

// ==== verif/data_mem_tb_model.svh ====
`ifndef DATA_MEM_TB_MODEL_SVH
`define DATA_MEM_TB_MODEL_SVH

// Byte image of what the DUT should hold
logic [7:0] shadow [`MEM_BYTES];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	return x ^ (x << 5);
endfunction

function automatic int size_bytes(input data_mem_pkg::mem_size_e size);
	case (size)
		data_mem_pkg::size_b, data_mem_pkg::size_bu: return 1;
		data_mem_pkg::size_h, data_mem_pkg::size_hu: return 2;
		default:                                     return 4;
	endcase
endfunction

// Applies a store to the shadow and returns the response owed for r
function automatic data_mem_pkg::mem_rsp_t predict_response(input data_mem_pkg::mem_req_t r);
	data_mem_pkg::mem_rsp_t res;
	logic [32:0]            last;
	logic [31:0]            val;
	int                     n;
	n         = size_bytes(r.size);
	last      = {1'b0, r.addr} + 33'(n);
	val       = '0;
	res.op    = r.op;
	res.err   = last > 33'(`MEM_BYTES);
	res.rdata = '0;
	if (res.err)
		return res;
	for (int i = 0; i < n; i++) begin
		if (r.op == data_mem_pkg::op_write)
			shadow[r.addr + i] = r.wdata[8*i +: 8];
		else
			val[8*i +: 8] = shadow[r.addr + i];
	end
	if (r.op == data_mem_pkg::op_write)
		return res;
	// Unsigned sizes are already zero-extended by val
	case (r.size)
		data_mem_pkg::size_b: res.rdata = {{24{val[7]}}, val[7:0]};
		data_mem_pkg::size_h: res.rdata = {{16{val[15]}}, val[15:0]};
		default:              res.rdata = val;
	endcase
	return res;
endfunction

`endif

// ==== verif/data_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "data_mem_cfg.svh"

module data_mem_tb;

	localparam logic [31:0] SEED        = 32'd45353;
	localparam int          MAX_STALL   = 4;
	localparam int          N_DIRECTED  = 64;
	localparam int          N_RANDOM    = 400;
	localparam int          N_OPS       = `MEM_ROWS + N_DIRECTED + N_RANDOM;
	// One idle cycle plus the longest stall per request
	localparam int          WATCHDOG_NS = N_OPS * (MAX_STALL + 2) * 10 + 2000;

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   req_valid;
	logic                   req_ready;
	data_mem_pkg::mem_req_t req;
	logic                   rsp_valid;
	logic                   rsp_ready;
	data_mem_pkg::mem_rsp_t rsp;

	logic                   stall_en;
	logic [31:0]            rnd_state;
	data_mem_pkg::mem_rsp_t exp_q [$];
	data_mem_pkg::mem_rsp_t exp_head;
	int                     exp_cnt;
	int                     val_errs;
	int                     proto_errs;

	`include "data_mem_tb_model.svh"

	data_mem i_dut (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	// Returns on the edge that accepts the request
	task automatic send(
		input data_mem_pkg::mem_op_e   op,
		input data_mem_pkg::mem_size_e size,
		input logic [31:0]             addr,
		input logic [31:0]             wdata
	);
		req_valid <= 1'b1;
		req.op    <= op;
		req.size  <= size;
		req.addr  <= addr;
		req.wdata <= wdata;
		@(posedge clk);
		while (!req_ready)
			@(posedge clk);
	endtask

	task automatic protocol_error(input string msg);
		proto_errs++;
		$display("%0d ns: %s", $time, msg);
	endtask

	// Expected responses in acceptance order
	always @(posedge clk) begin
		if (!rst) begin
			if (rsp_valid && rsp_ready && exp_q.size() != 0)
				void'(exp_q.pop_front());
			if (req_valid && req_ready)
				exp_q.push_back(predict_response(req));
			exp_cnt <= exp_q.size();
			if (exp_q.size() != 0)
				exp_head <= exp_q[0];
		end
	end

	a_reset_idle: assert property (
		@(posedge clk) !rst && $past(rst) |-> !rsp_valid && req_ready
	) else protocol_error("DUT not idle after reset");

	// Request into an empty slot is answered on the next edge
	a_rsp_latency: assert property (
		@(posedge clk) disable iff (rst)
		req_valid && req_ready ##1 !rsp_valid |=> rsp_valid
	) else protocol_error("no response one cycle after an accepted request");

	a_rsp_held: assert property (
		@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
	) else protocol_error("held response changed or was dropped");

	a_stall_blocks_req: assert property (
		@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |-> !req_ready
	) else protocol_error("req_ready high while the response is stalled");

	a_rsp_value: assert property (
		@(posedge clk) disable iff (rst)
		rsp_valid && rsp_ready |-> exp_cnt != 0 && rsp == exp_head
	) else begin
		val_errs++;
		$display("[FAIL] %0d ns: response %09h, expected %09h with %0d outstanding",
			$time, $sampled(rsp), $sampled(exp_head), $sampled(exp_cnt));
	end

	// Consumer that drops rsp_ready for 1 to MAX_STALL cycles
	initial begin : ready_gen
		logic [31:0] s;
		s         = ~SEED;
		rsp_ready = 1'b1;
		forever begin
			@(posedge clk);
			s = xorshift32(s);
			if (stall_en && s[1:0] == 2'd0) begin
				rsp_ready <= 1'b0;
				repeat (1 + s[7:4] % MAX_STALL) @(posedge clk);
			end
			rsp_ready <= 1'b1;
		end
	end

	initial begin : stimulus
		logic [31:0] pick;
		logic [31:0] addr;
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		stall_en  = 1'b0;
		rnd_state = SEED;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// Fill pattern mixes every address bit
		for (int a = 0; a < `MEM_BYTES; a += 4)
			send(data_mem_pkg::op_write, data_mem_pkg::size_w, a, 32'h9e3779b9 * (a + 1));

		// Word round trips at offsets 0 to 3 and across rows
		for (int i = 0; i < 6; i++)
			send(data_mem_pkg::op_write, data_mem_pkg::size_w, 32'h100 + 9 * i, next_rand());
		for (int i = 0; i < 6; i++)
			send(data_mem_pkg::op_read, data_mem_pkg::size_w, 32'h100 + 9 * i, '0);

		// Every load size at every offset with sign bits set
		send(data_mem_pkg::op_write, data_mem_pkg::size_w, 32'h200, 32'h80ff7f01);
		for (int a = 'h200; a < 'h204; a++) begin
			for (int s = 0; s < 5; s++)
				send(data_mem_pkg::op_read, data_mem_pkg::mem_size_e'(s), a, '0);
		end

		// Narrow stores side by side then word reads over them
		send(data_mem_pkg::op_write, data_mem_pkg::size_b, 32'h241, 32'h000000aa);
		send(data_mem_pkg::op_write, data_mem_pkg::size_h, 32'h246, 32'h00001234);
		send(data_mem_pkg::op_write, data_mem_pkg::size_hu, 32'h24b, 32'hffff8765);
		for (int a = 'h240; a < 'h250; a += 3)
			send(data_mem_pkg::op_read, data_mem_pkg::size_w, a, '0);

		// Around the end of memory
		send(data_mem_pkg::op_write, data_mem_pkg::size_w, 32'h3fc, 32'h13579bdf);
		send(data_mem_pkg::op_write, data_mem_pkg::size_w, 32'h3fd, 32'h2468ace0);
		send(data_mem_pkg::op_write, data_mem_pkg::size_h, 32'h3ff, 32'h0000ffff);
		send(data_mem_pkg::op_write, data_mem_pkg::size_b, `MEM_BYTES, 32'h55);
		send(data_mem_pkg::op_write, data_mem_pkg::size_w, 32'hffff_fffe, 32'h0);
		send(data_mem_pkg::op_read, data_mem_pkg::size_w, 32'h3fe, '0);
		send(data_mem_pkg::op_read, data_mem_pkg::size_w, 32'h3fc, '0);
		// Row 0 is where a wrapped lane would land
		send(data_mem_pkg::op_read, data_mem_pkg::size_w, 32'h0, '0);

		stall_en <= 1'b1;
		repeat (N_RANDOM) begin
			pick = next_rand();
			// Roughly one in ten near the end of memory
			if (pick[11:4] % 10 == 0)
				addr = `MEM_BYTES - 3 + pick[14:13];
			else
				addr = next_rand() % `MEM_BYTES;
			send(data_mem_pkg::mem_op_e'(pick[0]), data_mem_pkg::mem_size_e'(pick[3:1] % 3'd5),
				addr, next_rand());
			if (pick[18:16] == 3'd0) begin
				req_valid <= 1'b0;
				@(posedge clk);
			end
		end
		req_valid <= 1'b0;
		stall_en  <= 1'b0;
		@(posedge clk);
		while (exp_cnt != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);

		$display("Run complete: %0d value errors, %0d protocol errors", val_errs, proto_errs);
		if (val_errs + proto_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, responses missing or DUT stuck", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "data_mem_cfg.svh"

module data_mem (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  data_mem_pkg::mem_req_t req,
	output logic                   rsp_valid,
	input  logic                   rsp_ready,
	output data_mem_pkg::mem_rsp_t rsp
);

	logic                     slot_free;
	logic                     accept;
	data_mem_pkg::load_info_t info;
	data_mem_pkg::lane_cmd_t  lane_cmd [`MEM_LANES];
	logic [7:0]               lane_data [`MEM_LANES];

	mem_req_steer i_steer (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.slot_free (slot_free),
		.lane_cmd  (lane_cmd),
		.accept    (accept),
		.info      (info)
	);

	// One byte bank per lane
	for (genvar k = 0; k < `MEM_LANES; k++) begin : g_lane
		mem_byte_bank #(
			.DEPTH (`MEM_ROWS)
		) i_bank (
			.clk   (clk),
			.cmd   (lane_cmd[k]),
			.rdata (lane_data[k])
		);
	end

	mem_load_format i_format (
		.clk       (clk),
		.rst       (rst),
		.accept    (accept),
		.info      (info),
		.lane_data (lane_data),
		.slot_free (slot_free),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

// ==== hw/mem_load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "data_mem_cfg.svh"

module mem_load_format (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     accept,
	input  data_mem_pkg::load_info_t info,
	input  logic [7:0]               lane_data [`MEM_LANES],
	output logic                     slot_free,
	output logic                     rsp_valid,
	input  logic                     rsp_ready,
	output data_mem_pkg::mem_rsp_t   rsp
);

	typedef enum logic {
		slot_empty = 1'b0,
		slot_held  = 1'b1
	} slot_state_e;

	slot_state_e              slot_q;
	logic                     pend_q;
	data_mem_pkg::load_info_t info_q;
	data_mem_pkg::mem_rsp_t   rsp_q;
	data_mem_pkg::mem_rsp_t   rsp_d;
	logic [`MEM_DATA_W-1:0]   word;
	logic                     load_rsp;

	assign rsp_valid = slot_q == slot_held;
	assign rsp       = rsp_q;
	assign slot_free = !rsp_valid || rsp_ready;

	// Pending access moves into the slot as soon as the slot frees up
	assign load_rsp = pend_q && slot_free;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			slot_q <= slot_empty;
			pend_q <= 1'b0;
		end else begin
			pend_q <= accept || (pend_q && !slot_free);
			if (load_rsp)
				slot_q <= slot_held;
			else if (rsp_valid && rsp_ready)
				slot_q <= slot_empty;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			info_q <= info;
		if (load_rsp)
			rsp_q <= rsp_d;
	end

	// Lanes back into address order
	always_comb begin
		for (int j = 0; j < `MEM_LANES; j++)
			word[8*j +: 8] = lane_data[2'(j) + info_q.offs];
	end

	always_comb begin
		rsp_d.op  = info_q.op;
		rsp_d.err = info_q.err;
		case (info_q.size)
			data_mem_pkg::size_b:  rsp_d.rdata = {{24{word[7]}}, word[7:0]};
			data_mem_pkg::size_bu: rsp_d.rdata = {24'h0, word[7:0]};
			data_mem_pkg::size_h:  rsp_d.rdata = {{16{word[15]}}, word[15:0]};
			data_mem_pkg::size_hu: rsp_d.rdata = {16'h0, word[15:0]};
			default:               rsp_d.rdata = word;
		endcase
		if (info_q.err || info_q.op == data_mem_pkg::op_write)
			rsp_d.rdata = '0;
	end

	// Held response must not change before it is taken
	a_rsp_stable: assert property (
		@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
	) else $error("response changed while held");

endmodule

`default_nettype wire

// ==== hw/mem_byte_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "data_mem_cfg.svh"

module mem_byte_bank #(
	parameter int DEPTH = `MEM_ROWS
) (
	input  logic                    clk,
	input  data_mem_pkg::lane_cmd_t cmd,
	output logic [7:0]              rdata
);

	logic [7:0] mem [DEPTH];

	// Write-first, read data held while the lane is idle
	always_ff @(posedge clk) begin
		if (cmd.en) begin
			if (cmd.we) begin
				mem[cmd.row] <= cmd.wbyte;
				rdata        <= cmd.wbyte;
			end else begin
				rdata <= mem[cmd.row];
			end
		end
	end

	// Row comes from the steering block and must fit this lane
	a_row_in_range: assert property (
		@(posedge clk) cmd.en |-> (cmd.row < DEPTH)
	) else $error("lane row %0d beyond depth %0d", cmd.row, DEPTH);

endmodule

`default_nettype wire

// ==== hw/mem_req_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "data_mem_cfg.svh"

module mem_req_steer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  data_mem_pkg::mem_req_t   req,
	input  logic                     slot_free,
	output data_mem_pkg::lane_cmd_t  lane_cmd [`MEM_LANES],
	output logic                     accept,
	output data_mem_pkg::load_info_t info
);

	logic [2:0]             len;
	logic [`MEM_ADDR_W:0]   end_addr;
	logic                   err;
	logic [1:0]             start_lane;
	logic [`MEM_ROW_W-1:0]  start_row;
	logic [`MEM_ROW_W-1:0]  next_row;

	assign req_ready = slot_free;
	assign accept    = req_valid && slot_free;

	// Access length in bytes
	always_comb begin
		case (req.size)
			data_mem_pkg::size_b,
			data_mem_pkg::size_bu: len = 3'd1;
			data_mem_pkg::size_h,
			data_mem_pkg::size_hu: len = 3'd2;
			default:               len = 3'd4;
		endcase
	end

	// One extra bit so addresses near the top of the space cannot wrap
	assign end_addr = {1'b0, req.addr} + {{(`MEM_ADDR_W-2){1'b0}}, len};
	assign err      = end_addr > `MEM_BYTES;

	assign start_lane = req.addr[1:0];
	assign start_row  = req.addr[`MEM_ROW_W+1:2];
	assign next_row   = start_row + 1'b1;

	always_comb begin
		logic [1:0] offs;

		for (int k = 0; k < `MEM_LANES; k++) begin
			// Byte position within the access that lands on this lane
			offs = 2'(k) - start_lane;

			lane_cmd[k].en    = accept && !err && ({1'b0, offs} < len);
			lane_cmd[k].we    = req.op == data_mem_pkg::op_write;
			lane_cmd[k].row   = (2'(k) < start_lane) ? next_row : start_row;
			lane_cmd[k].wbyte = req.wdata[8*offs +: 8];
		end
	end

	assign info.op   = req.op;
	assign info.size = req.size;
	assign info.offs = start_lane;
	assign info.err  = err;

	// Requester must hold a stalled request unchanged
	a_req_stable: assert property (
		@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> req_valid && $stable(req)
	) else $error("request changed or withdrawn while stalled");

endmodule

`default_nettype wire

// ==== hw/data_mem_pkg.sv ====
`default_nettype none

`include "data_mem_cfg.svh"

package data_mem_pkg;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} mem_op_e;

	// Stores treat the unsigned sizes like the signed ones
	typedef enum logic [2:0] {
		size_b  = 3'd0,
		size_h  = 3'd1,
		size_w  = 3'd2,
		size_bu = 3'd3,
		size_hu = 3'd4
	} mem_size_e;

	typedef struct packed {
		mem_op_e                 op;
		mem_size_e               size;
		logic [`MEM_ADDR_W-1:0]  addr;
		logic [`MEM_DATA_W-1:0]  wdata;
	} mem_req_t;

	typedef struct packed {
		mem_op_e                 op;
		logic                    err;
		logic [`MEM_DATA_W-1:0]  rdata;
	} mem_rsp_t;

	// Command for one byte lane
	typedef struct packed {
		logic                    en;
		logic                    we;
		logic [`MEM_ROW_W-1:0]   row;
		logic [7:0]              wbyte;
	} lane_cmd_t;

	// What the formatter needs to rebuild the response
	typedef struct packed {
		mem_op_e                 op;
		mem_size_e               size;
		logic [1:0]              offs;
		logic                    err;
	} load_info_t;

endpackage

`default_nettype wire

// ==== hw/data_mem_cfg.svh ====
`ifndef DATA_MEM_CFG_SVH
`define DATA_MEM_CFG_SVH

// Total memory size in bytes
`define MEM_BYTES 1024

// Byte lanes, one per byte of the data word
`define MEM_LANES 4

`define MEM_ROWS (`MEM_BYTES / `MEM_LANES)
`define MEM_ROW_W $clog2(`MEM_ROWS)

`define MEM_ADDR_W 32
`define MEM_DATA_W 32

`endif
